/* exu_alu.f */
+incdir+include
hdl/alu_pkg.sv
hdl/branch_pkg.sv
hdl/alu_compare_stage.sv
hdl/alu_shifter.sv
hdl/alu_bit_count.sv
hdl/alu_result_stage.sv
hdl/exu_alu_top.sv
sim/alu_tb.sv

/* Makefile */
# Verilator build and run for the two-stage ALU pipeline

TOP       ?= alu_tb
FILELIST  ?= exu_alu.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run $(TOP), pass or fail from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/alu_ref_model.svh */
//////////////////////////////////////////////////////////////////////
// reference model for the ALU testbench, include inside a module
// that imports alu_pkg and branch_pkg
//////////////////////////////////////////////////////////////////////
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// expected result word for one operation
function automatic word_t ref_result(alu_op_e op, word_t a, word_t b);
   logic [5:0] sh;
   int         n;
   sh = {1'b0, b[4:0]};
   n  = 0;
   case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_SLT:  return word_t'($signed(a) < $signed(b));
      OP_SLTU: return word_t'(a < b);
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ANDN: return a & ~b;
      OP_ORN:  return a | ~b;
      OP_XNOR: return ~(a ^ b);
      OP_SLL:  return a << sh;
      OP_SRL:  return a >> sh;
      OP_SRA:  return word_t'($signed(a) >>> sh);
      OP_ROL:  return (a << sh) | (a >> (6'd32 - sh));
      OP_ROR:  return (a >> sh) | (a << (6'd32 - sh));
      OP_CLZ:
      begin
         while (n < 32 && !a[31 - n])
            n++;
         return word_t'(n);
      end
      OP_CTZ:
      begin
         while (n < 32 && !a[n])
            n++;
         return word_t'(n);
      end
      OP_CPOP: return word_t'($countones(a));
      OP_MIN:  return ($signed(a) < $signed(b)) ? a : b;
      OP_MAX:  return ($signed(a) < $signed(b)) ? b : a;
      OP_MINU: return (a < b) ? a : b;
      OP_MAXU: return (a < b) ? b : a;
      default: return '0;
   endcase
endfunction

// expected branch decision, zero when the op is not a branch
function automatic logic ref_taken(br_cond_e cond, word_t a, word_t b);
   case (cond)
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return $signed(a) < $signed(b);
      BR_GE:   return $signed(a) >= $signed(b);
      BR_LTU:  return a < b;
      BR_GEU:  return a >= b;
      default: return 1'b0;
   endcase
endfunction

`endif

/* sim/alu_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the two-stage ALU pipeline, directed and LFSR tests
// checked against the reference model through a scoreboard queue
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_tb
   import alu_pkg::*;
   import branch_pkg::*;
();

`include "alu_ref_model.svh"

   localparam int MAX_WAIT = 64;

   logic     clk = 1'b0;
   logic     rst_n;
   logic     enable;
   logic     valid;
   alu_op_e  op;
   br_cond_e cond;
   word_t    a;
   word_t    b;
   logic     result_valid;
   logic     br_taken;
   word_t    result;

   logic [15:0] lfsr = 16'd45502;
   word_t       exp_res_q[$];
   logic        exp_tk_q[$];
   int          stamp_q[$];
   int          en_count = 0;
   logic        edge_en = 1'b0;
   logic        edge_hold = 1'b0;
   logic        last_rv = 1'b0;
   word_t       last_res = '0;
   logic        last_tk = 1'b0;
   int          value_errs = 0;
   int          ctrl_errs = 0;

   always #4 clk = ~clk;

   exu_alu_top dut0
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .enable       (enable),
      .valid        (valid),
      .op           (op),
      .cond         (cond),
      .a            (a),
      .b            (b),
      .result_valid (result_valid),
      .br_taken     (br_taken),
      .result       (result)
   );

   // taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // corner values show up in three of eight picks
   task automatic pick_operand(output word_t w);
      logic [31:0] bits;
      take_bits(3, bits);
      case (bits[2:0])
         3'd0:    w = '0;
         3'd1:    w = 32'hffff_ffff;
         3'd2:    w = 32'h8000_0000;
         default: take_bits(32, w);
      endcase
   endtask

   task automatic report_timeout(input string msg);
      $display("%s", msg);
      ctrl_errs++;
   endtask

   // hold the op on the inputs until an enabled edge takes it
   task automatic issue_op(alu_op_e o, br_cond_e c, word_t x, word_t y, bit rand_en);
      logic [31:0] bits;
      int          waits;
      waits = 0;
      valid <= 1'b1;
      op    <= o;
      cond  <= c;
      a     <= x;
      b     <= y;
      take_bits(2, bits);
      enable <= !rand_en || (bits[1:0] != 2'b00);
      @(posedge clk);
      while (!enable && waits < MAX_WAIT)
      begin
         take_bits(2, bits);
         enable <= (bits[1:0] != 2'b00);
         waits++;
         @(posedge clk);
      end
      if (!enable)
         report_timeout("timeout, operation was never accepted, enable stayed low");
   endtask

   task automatic idle_cycles(input int n);
      logic [31:0] bits;
      valid <= 1'b0;
      for (int i = 0; i < n; i++)
      begin
         take_bits(1, bits);
         enable <= bits[0];
         @(posedge clk);
      end
   endtask

   task automatic drain_pipeline();
      int waits;
      waits = 0;
      valid  <= 1'b0;
      enable <= 1'b1;
      while (exp_res_q.size() != 0 && waits < MAX_WAIT)
      begin
         @(posedge clk);
         waits++;
      end
      if (exp_res_q.size() != 0)
         report_timeout("timeout, outstanding operations never produced a result");
      // catch any extra result after the last one
      repeat (4) @(posedge clk);
      @(negedge clk);
   endtask

   // scoreboard push at the accepting edge
   always @(posedge clk)
   begin
      edge_en   <= rst_n && enable;
      edge_hold <= rst_n && !enable;
      if (rst_n && enable)
      begin
         en_count <= en_count + 1;
         if (valid)
         begin
            exp_res_q.push_back(ref_result(op, a, b));
            exp_tk_q.push_back(ref_taken(cond, a, b));
            stamp_q.push_back(en_count);
         end
      end
   end

   // outputs are stable at the falling edge
   always @(negedge clk)
   begin
      word_t exp_res;
      logic  exp_tk;
      int    lat;
      if (edge_en && result_valid)
      begin
         assert (exp_res_q.size() != 0)
         else
         begin
            $display("result_valid was set with no operation outstanding");
            ctrl_errs++;
         end
         if (exp_res_q.size() != 0)
         begin
            exp_res = exp_res_q.pop_front();
            exp_tk  = exp_tk_q.pop_front();
            lat     = en_count - stamp_q.pop_front();
            assert (result == exp_res)
            else
            begin
               $display("ERROR result: got %h expected %h", result, exp_res);
               value_errs++;
            end
            assert (br_taken == exp_tk)
            else
            begin
               $display("ERROR br_taken: got %h expected %h", br_taken, exp_tk);
               value_errs++;
            end
            assert (lat == 2)
            else
            begin
               $display("result arrived %0d enabled cycles after issue, not 2", lat);
               ctrl_errs++;
            end
         end
      end
      // a disabled edge must leave every output alone
      if (edge_hold)
      begin
         assert (result_valid == last_rv)
         else
         begin
            $display("ERROR result_valid: got %h expected %h", result_valid, last_rv);
            ctrl_errs++;
         end
         assert (result == last_res)
         else
         begin
            $display("ERROR result: got %h expected %h", result, last_res);
            ctrl_errs++;
         end
         assert (br_taken == last_tk)
         else
         begin
            $display("ERROR br_taken: got %h expected %h", br_taken, last_tk);
            ctrl_errs++;
         end
      end
      last_rv  = result_valid;
      last_res = result;
      last_tk  = br_taken;
   end

   initial
   begin
      word_t       pa[6];
      word_t       pb[6];
      word_t       x;
      word_t       y;
      alu_op_e     rop;
      logic [31:0] bits;
      rst_n  = 1'b0;
      enable = 1'b0;
      valid  = 1'b0;
      op     = OP_ADD;
      cond   = BR_NONE;
      a      = '0;
      b      = '0;
      // equal pair, carries, amount 31, amount 0, zero word, amount 5
      pa = '{32'h1234_5678, 32'hffff_ffff, 32'h8000_0000,
             32'h9234_5679, 32'h0000_0000, 32'h0f0f_1234};
      pb = '{32'h1234_5678, 32'h0000_0001, 32'h7fff_ffff,
             32'h0000_0000, 32'hffff_ffff, 32'hff00_00e5};
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      assert (result_valid == 1'b0 && result == '0 && br_taken == 1'b0)
      else
      begin
         $display("outputs were not cleared by reset");
         ctrl_errs++;
      end
      @(posedge clk);

      // every op and condition on each pair, even pairs back to back
      for (int p = 0; p < 6; p++)
      begin
         for (int i = 0; i <= int'(OP_MAXU); i++)
            issue_op(alu_op_e'(i), br_cond_e'(i % 7), pa[p], pb[p], p[0]);
         idle_cycles(3);
      end

      for (int n = 0; n < 400; n++)
      begin
         take_bits(5, bits);
         rop = alu_op_e'(bits[4:0] % 5'd22);
         take_bits(3, bits);
         pick_operand(x);
         pick_operand(y);
         issue_op(rop, br_cond_e'(bits[2:0] % 3'd7), x, y, 1'b1);
         take_bits(3, bits);
         if (bits[2:0] == 3'd0)
            idle_cycles(2);
      end

      drain_pipeline();
      $display("value errors: %0d, control errors: %0d", value_errs, ctrl_errs);
      if (value_errs + ctrl_errs == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* hdl/exu_alu_top.sv */
//////////////////////////////////////////////////////////////////////
// two-stage ALU pipeline, two enabled cycles from issue to result
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module exu_alu_top
   import alu_pkg::*;
   import branch_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     enable,
   input  logic     valid,
   input  alu_op_e  op,
   input  br_cond_e cond,
   input  word_t    a,
   input  word_t    b,
   output logic     result_valid,
   output logic     br_taken,
   output word_t    result
);

   logic     s1_valid;
   alu_op_e  s1_op;
   br_cond_e s1_cond;
   word_t    s1_a;
   word_t    s1_b;
   word_t    s1_sum;
   logic     s1_eq;
   logic     s1_lt_s;
   logic     s1_lt_u;

   alu_compare_stage u_compare
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (enable),
      .valid    (valid),
      .op       (op),
      .cond     (cond),
      .a        (a),
      .b        (b),
      .s1_valid (s1_valid),
      .s1_op    (s1_op),
      .s1_cond  (s1_cond),
      .s1_a     (s1_a),
      .s1_b     (s1_b),
      .s1_sum   (s1_sum),
      .s1_eq    (s1_eq),
      .s1_lt_s  (s1_lt_s),
      .s1_lt_u  (s1_lt_u)
   );

   alu_result_stage u_result
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .enable       (enable),
      .s1_valid     (s1_valid),
      .s1_op        (s1_op),
      .s1_cond      (s1_cond),
      .s1_a         (s1_a),
      .s1_b         (s1_b),
      .s1_sum       (s1_sum),
      .s1_eq        (s1_eq),
      .s1_lt_s      (s1_lt_s),
      .s1_lt_u      (s1_lt_u),
      .result_valid (result_valid),
      .br_taken     (br_taken),
      .result       (result)
   );

endmodule

/* hdl/alu_result_stage.sv */
//////////////////////////////////////////////////////////////////////
// second ALU stage: logic, shift, count and min/max units, result
// select, branch resolution and the output registers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_result_stage
   import alu_pkg::*;
   import branch_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     enable,
   input  logic     s1_valid,
   input  alu_op_e  s1_op,
   input  br_cond_e s1_cond,
   input  word_t    s1_a,
   input  word_t    s1_b,
   input  word_t    s1_sum,
   input  logic     s1_eq,
   input  logic     s1_lt_s,
   input  logic     s1_lt_u,
   output logic     result_valid,
   output logic     br_taken,
   output word_t    result
);

   word_t  shift_out;
   count_t bit_count;
   word_t  result_d;
   logic   taken_d;

   alu_shifter u_shifter
   (
      .op        (s1_op),
      .a         (s1_a),
      .amount    (s1_b[4:0]),
      .shift_out (shift_out)
   );

   alu_bit_count u_bit_count
   (
      .op    (s1_op),
      .a     (s1_a),
      .count (bit_count)
   );

   // min picks a and max picks b when a < b, else the other operand
   always_comb
   begin
      case (s1_op)
         OP_ADD,
         OP_SUB:  result_d = s1_sum;
         OP_SLT:  result_d = word_t'(s1_lt_s);
         OP_SLTU: result_d = word_t'(s1_lt_u);
         OP_AND:  result_d = s1_a & s1_b;
         OP_OR:   result_d = s1_a | s1_b;
         OP_XOR:  result_d = s1_a ^ s1_b;
         OP_ANDN: result_d = s1_a & ~s1_b;
         OP_ORN:  result_d = s1_a | ~s1_b;
         OP_XNOR: result_d = s1_a ^ ~s1_b;
         OP_SLL,
         OP_SRL,
         OP_SRA,
         OP_ROL,
         OP_ROR:  result_d = shift_out;
         OP_CLZ,
         OP_CTZ,
         OP_CPOP: result_d = word_t'(bit_count);
         OP_MIN:  result_d = s1_lt_s ? s1_a : s1_b;
         OP_MAX:  result_d = s1_lt_s ? s1_b : s1_a;
         OP_MINU: result_d = s1_lt_u ? s1_a : s1_b;
         OP_MAXU: result_d = s1_lt_u ? s1_b : s1_a;
         default: result_d = '0;
      endcase
   end

   always_comb
   begin
      case (s1_cond)
         BR_EQ:   taken_d = s1_eq;
         BR_NE:   taken_d = ~s1_eq;
         BR_LT:   taken_d = s1_lt_s;
         BR_GE:   taken_d = ~s1_lt_s;
         BR_LTU:  taken_d = s1_lt_u;
         BR_GEU:  taken_d = ~s1_lt_u;
         default: taken_d = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         result_valid <= 1'b0;
         result       <= '0;
         br_taken     <= 1'b0;
      end
      else if (enable)
      begin
         result_valid <= s1_valid;
         // outputs keep the last result between valid ops
         if (s1_valid)
         begin
            result   <= result_d;
            br_taken <= taken_d;
         end
      end
   end

endmodule

/* hdl/alu_bit_count.sv */
//////////////////////////////////////////////////////////////////////
// leading zero, trailing zero and population count of operand a
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_bit_count
   import alu_pkg::*;
(
   input  alu_op_e op,
   input  word_t   a,
   output count_t  count
);

   word_t  a_reverse;
   word_t  lzd_in;
   count_t lz_count;
   count_t pop_count;
   logic   found;

   // ctz is clz of the bit-reversed word
   assign a_reverse = {<<{a}};
   assign lzd_in    = (op == OP_CTZ) ? a_reverse : a;

   // zeros above the first one, 32 when the word is zero
   always_comb
   begin
      lz_count = '0;
      found    = 1'b0;
      for (int i = 31; i >= 0; i--)
      begin
         if (!found)
         begin
            if (lzd_in[i])
               found = 1'b1;
            else
               lz_count = lz_count + count_t'(1);
         end
      end
   end

   always_comb
   begin
      pop_count = '0;
      for (int i = 0; i < 32; i++)
         pop_count = pop_count + count_t'(a[i]);
   end

   assign count = ((op == OP_CLZ) || (op == OP_CTZ)) ? lz_count  :
                  (op == OP_CPOP)                     ? pop_count : '0;

endmodule

/* hdl/alu_shifter.sv */
//////////////////////////////////////////////////////////////////////
// shift and rotate unit, one 63-bit right shifter for all five ops
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_shifter
   import alu_pkg::*;
(
   input  alu_op_e op,
   input  word_t   a,
   input  shamt_t  amount,
   output word_t   shift_out
);

   logic        shift_left;
   shamt_t      right_amt;
   logic [30:0] ext_upper;
   logic [62:0] shift_extend;
   logic [62:0] shift_long;
   word_t       shift_mask;

   // left shifts become a right shift by 32 - amount
   assign shift_left = (op == OP_SLL) || (op == OP_ROL);
   assign right_amt  = shift_left ? (5'd0 - amount) : amount;

   // upper half holds sign copies for sra, or a wrapped copy of a
   always_comb
   begin
      case (op)
         OP_SRA:  ext_upper = {31{a[31]}};
         OP_SLL,
         OP_ROL,
         OP_ROR:  ext_upper = a[30:0];
         default: ext_upper = '0;
      endcase
   end

   assign shift_extend = {ext_upper, a};
   assign shift_long   = shift_extend >> right_amt;

   // sll drops the bits that wrapped in from the top
   assign shift_mask = 32'hffff_ffff << ((op == OP_SLL) ? amount : 5'd0);

   assign shift_out = shift_long[31:0] & shift_mask;

endmodule

/* hdl/alu_compare_stage.sv */
//////////////////////////////////////////////////////////////////////
// first ALU stage: adder, compare flags and the stage 1 registers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_compare_stage
   import alu_pkg::*;
   import branch_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     enable,
   input  logic     valid,
   input  alu_op_e  op,
   input  br_cond_e cond,
   input  word_t    a,
   input  word_t    b,
   output logic     s1_valid,
   output alu_op_e  s1_op,
   output br_cond_e s1_cond,
   output word_t    s1_a,
   output word_t    s1_b,
   output word_t    s1_sum,
   output logic     s1_eq,
   output logic     s1_lt_s,
   output logic     s1_lt_u
);

   logic        is_sub;
   word_t       b_opnd;
   word_t       sum;
   logic [32:0] diff_full;
   logic        ov;

   // add or sub result for the arithmetic ops
   assign is_sub = (op == OP_SUB);
   assign b_opnd = is_sub ? ~b : b;
   assign sum    = a + b_opnd + word_t'(is_sub);

   // the compare always uses a - b, whatever the op
   assign diff_full = {1'b0, a} + {1'b0, ~b} + 33'd1;

   // signed overflow when operand signs differ and the sign flips
   assign ov = (~a[31] &  b[31] &  diff_full[31]) |
               ( a[31] & ~b[31] & ~diff_full[31]);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         s1_valid <= 1'b0;
         s1_op    <= OP_ADD;
         s1_cond  <= BR_NONE;
         s1_a     <= '0;
         s1_b     <= '0;
         s1_sum   <= '0;
         s1_eq    <= 1'b0;
         s1_lt_s  <= 1'b0;
         s1_lt_u  <= 1'b0;
      end
      else if (enable)
      begin
         s1_valid <= valid;
         if (valid)
         begin
            s1_op   <= op;
            s1_cond <= cond;
            s1_a    <= a;
            s1_b    <= b;
            s1_sum  <= sum;
            s1_eq   <= (diff_full[31:0] == '0);
            // sign xor overflow for signed, no carry out for unsigned
            s1_lt_s <= diff_full[31] ^ ov;
            s1_lt_u <= ~diff_full[32];
         end
      end
   end

endmodule

/* hdl/branch_pkg.sv */
//////////////////////////////////////////////////////////////////////
// conditional branch encodings resolved in the second ALU stage
//////////////////////////////////////////////////////////////////////

package branch_pkg;

   // BR_NONE marks an operation that is not a branch
   typedef enum logic [2:0]
   {
      BR_NONE,
      BR_EQ,
      BR_NE,
      BR_LT,
      BR_GE,
      BR_LTU,
      BR_GEU
   } br_cond_e;

endpackage

/* hdl/alu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// data widths and operation codes shared by both ALU pipeline stages
// import with a wildcard in the module header
//////////////////////////////////////////////////////////////////////

package alu_pkg;

   localparam int WORD_W = 32;

   // operand and result word of the 32-bit ISA
   typedef logic [WORD_W-1:0] word_t;

   // shift and rotate amount, low bits of operand b
   typedef logic [4:0] shamt_t;

   // clz, ctz and cpop result, 0 to 32
   typedef logic [5:0] count_t;

   typedef enum logic [4:0]
   {
      OP_ADD,  OP_SUB,
      OP_SLT,  OP_SLTU,
      OP_AND,  OP_OR,   OP_XOR,
      OP_ANDN, OP_ORN,  OP_XNOR,
      OP_SLL,  OP_SRL,  OP_SRA,
      OP_ROL,  OP_ROR,
      OP_CLZ,  OP_CTZ,  OP_CPOP,
      OP_MIN,  OP_MAX,  OP_MINU, OP_MAXU
   } alu_op_e;

endpackage
